// File: filelist.f
+incdir+source
source/rv_pkg.sv
source/stage_latch.sv
source/id_decoder.sv
source/id_stage.sv
source/ex_stage.sv
source/wb_stage.sv
source/rv_core_top.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/rv_core_sim +verilator+error+limit+1000)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi

// File: verification/rv_core_tb.sv
/* Core testbench, clock and reset, program stimulus, reference model
   and commit checks */

`default_nettype none

`include "rv_settings.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_DIRECTED  = 21;
  localparam int N_RANDOM    = 39;
  localparam int N_INSTR     = N_DIRECTED + N_RANDOM;
  localparam int CYCLE_LIMIT = N_INSTR * 16 + 40;   // Worst case stalls plus drain
  localparam logic [`BUS_64] PC_BASE = 64'h1000;

  typedef struct packed {
    logic [`BUS_64]   pc;
    logic [`BUS_RIDX] rd;
    logic             wen;
    logic [`BUS_64]   data;
    logic             skip;
  } commit_t;

  logic             clk;
  logic             rst;
  logic             i_fetched_req;
  logic [`BUS_64]   i_pc;
  logic [`BUS_32]   i_inst;
  logic             i_commit_ack;
  logic             o_fetch_ready;
  logic             o_commit_req;
  logic [`BUS_64]   o_commit_pc;
  logic [`BUS_RIDX] o_commit_rd;
  logic             o_commit_wen;
  logic [`BUS_64]   o_commit_data;
  logic             o_commit_skip;

  commit_t        exp_q[$];
  logic [`BUS_64] model_regs [0:`REG_COUNT-1];
  logic [`BUS_32] prog [0:N_INSTR-1];
  integer         seed = 5802;
  logic [31:0]    rnd;
  bit             ack_random;
  int             errors;
  int             checks;
  int             cycles;
  int             total;

  rv_core_top i_dut (.*);

  bind rv_core_top rv_core_props u_props (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ******************************
  // Encoders and reference model
  // ******************************
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic predict_commit(input logic [31:0] inst, input logic [63:0] pc);
    commit_t     c;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [9:0]  f73;
    a        = model_regs[inst[19:15]];
    b        = model_regs[inst[24:20]];
    imm      = {{52{inst[31]}}, inst[31:20]};
    f73      = {inst[31:25], inst[14:12]};
    c.pc     = pc;
    c.rd     = inst[11:7];
    c.skip   = 1'b0;
    c.data   = '0;
    case (inst[6:0])
      7'b0010011: begin
        if (inst[14:12] == 3'd0) c.data = a + imm;
        else if (inst[14:12] == 3'd1 && inst[31:26] == 6'd0) c.data = a << inst[25:20];
        else if (inst[14:12] == 3'd5 && inst[31:26] == 6'd0) c.data = a >> inst[25:20];
        else c.skip = 1'b1;
      end
      7'b0110011: begin
        case (f73)
          10'b0000000_000: c.data = a + b;
          10'b0100000_000: c.data = a - b;
          10'b0000000_111: c.data = a & b;
          10'b0000000_110: c.data = a | b;
          10'b0000000_100: c.data = a ^ b;
          default:         c.skip = 1'b1;
        endcase
      end
      7'b0110111: c.data = {{32{inst[31]}}, inst[31:12], 12'h000};
      default:    c.skip = 1'b1;
    endcase
    c.wen = !c.skip && (c.rd != 5'd0);
    if (c.wen) model_regs[c.rd] = c.data;
    exp_q.push_back(c);
  endtask

  task automatic build_program();
    int kind;
    prog[0]  = enc_u(20'h12345, 5'd1);
    prog[1]  = enc_i(12'h678, 5'd1, 3'd0, 5'd1);   // Depends on the LUI
    prog[2]  = enc_i(12'hffb, 5'd0, 3'd0, 5'd2);
    prog[3]  = enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
    prog[4]  = enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd4);
    prog[5]  = enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd5);
    prog[6]  = enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd6);
    prog[7]  = enc_r(7'h00, 5'd4, 5'd3, 3'd4, 5'd7);
    prog[8]  = enc_i({6'd0, 6'd33}, 5'd1, 3'd1, 5'd8);
    prog[9]  = enc_i({6'd0, 6'd7}, 5'd2, 3'd5, 5'd9);
    prog[10] = enc_i(12'h001, 5'd1, 3'd0, 5'd0);   // x0 destination
    prog[11] = enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd10);
    prog[12] = enc_u(20'hfffff, 5'd0);
    prog[13] = 32'h0000_0073;
    prog[14] = 32'hffff_ffff;
    prog[15] = enc_i({6'b010000, 6'd3}, 5'd2, 3'd5, 5'd11);   // Arithmetic shift is skipped
    prog[16] = enc_i(12'h001, 5'd12, 3'd0, 5'd12);
    prog[17] = enc_i(12'h001, 5'd12, 3'd0, 5'd12);
    prog[18] = enc_i(12'h001, 5'd12, 3'd0, 5'd12);
    prog[19] = enc_r(7'h00, 5'd12, 5'd12, 3'd0, 5'd13);
    prog[20] = enc_r(7'h00, 5'd31, 5'd11, 3'd0, 5'd14);   // Skipped words left x11 and x31 zero
    for (int n = N_DIRECTED; n < N_INSTR; n++) begin
      rnd  = $random(seed);
      kind = int'(rnd[31:24]) % 10;
      // Registers x0 to x7 only for frequent dependencies
      case (kind)
        0: prog[n] = enc_u(rnd[27:8], {2'b0, rnd[2:0]});
        1: prog[n] = enc_i(rnd[23:12], {2'b0, rnd[5:3]}, 3'd0, {2'b0, rnd[2:0]});
        2: prog[n] = enc_i({6'd0, rnd[21:16]}, {2'b0, rnd[5:3]}, 3'd1, {2'b0, rnd[2:0]});
        3: prog[n] = enc_i({6'd0, rnd[21:16]}, {2'b0, rnd[5:3]}, 3'd5, {2'b0, rnd[2:0]});
        4: prog[n] = enc_r(7'h00, {2'b0, rnd[8:6]}, {2'b0, rnd[5:3]}, 3'd0, {2'b0, rnd[2:0]});
        5: prog[n] = enc_r(7'h20, {2'b0, rnd[8:6]}, {2'b0, rnd[5:3]}, 3'd0, {2'b0, rnd[2:0]});
        6: prog[n] = enc_r(7'h00, {2'b0, rnd[8:6]}, {2'b0, rnd[5:3]}, 3'd7, {2'b0, rnd[2:0]});
        7: prog[n] = enc_r(7'h00, {2'b0, rnd[8:6]}, {2'b0, rnd[5:3]}, 3'd6, {2'b0, rnd[2:0]});
        8: prog[n] = enc_r(7'h00, {2'b0, rnd[8:6]}, {2'b0, rnd[5:3]}, 3'd4, {2'b0, rnd[2:0]});
        default: prog[n] = $random(seed);   // Mostly unknown words
      endcase
    end
  endtask

  // Commit ack for the next cycle, random once the random part starts
  function automatic logic next_ack();
    logic [31:0] r;
    if (!ack_random) begin
      return 1'b1;
    end
    r = $random(seed);
    return r[0];
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ******************************
  // Commit checks
  // ******************************
  always @(posedge clk) begin
    commit_t e;
    if (!rst && o_commit_req && i_commit_ack) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected commit at time %0t with pc %h", $time, o_commit_pc);
      end else begin
        e = exp_q.pop_front();
        check_field("o_commit_pc", o_commit_pc, e.pc);
        check_field("o_commit_skip", 64'(o_commit_skip), 64'(e.skip));
        check_field("o_commit_wen", 64'(o_commit_wen), 64'(e.wen));
        if (!e.skip) begin
          check_field("o_commit_rd", 64'(o_commit_rd), 64'(e.rd));
          check_field("o_commit_data", o_commit_data, e.data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d commits missing", cycles, exp_q.size());
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int   n;
    logic ready_now;
    logic ack_next;
    rst           = 1'b1;
    i_fetched_req = 1'b0;
    i_pc          = '0;
    i_inst        = '0;
    i_commit_ack  = 1'b1;
    ack_random    = 1'b0;
    for (int r = 0; r < `REG_COUNT; r++) model_regs[r] = '0;
    build_program();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    n   = 0;
    while (n < N_INSTR) begin
      ready_now = o_fetch_ready;
      if (n >= N_DIRECTED) ack_random = 1'b1;
      ack_next = next_ack();
      // A falling ack can take away the fetch ready seen here
      if (ready_now && (ack_next || !i_commit_ack)) begin
        i_fetched_req = 1'b1;
        i_pc          = PC_BASE + 64'(n) * 64'd4;
        i_inst        = prog[n];
        predict_commit(prog[n], i_pc);
        n++;
      end else begin
        i_fetched_req = 1'b0;
      end
      i_commit_ack = ack_next;
      @(negedge clk);
    end
    i_fetched_req = 1'b0;
    while (exp_q.size() != 0) begin
      i_commit_ack = next_ack();
      @(negedge clk);
    end
    i_commit_ack = 1'b1;
    repeat (3) @(negedge clk);
    total = errors + int'(i_dut.u_props.fail_count);
    $display("Checks: %0d  Errors: %0d  Property failures: %0d",
             checks, errors, i_dut.u_props.fail_count);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/rv_core_props.sv
/* Handshake, back-pressure, latency and reset properties for the core top,
   attached by bind */

`default_nettype none

`include "rv_settings.svh"

module rv_core_props (
  input wire             clk,
  input wire             rst,
  input wire             i_fetched_req,
  input wire             i_commit_ack,
  input wire             o_fetch_ready,
  input wire             o_commit_req,
  input wire [`BUS_64]   o_commit_pc,
  input wire [`BUS_RIDX] o_commit_rd,
  input wire             o_commit_wen,
  input wire [`BUS_64]   o_commit_data,
  input wire             o_commit_skip,
  input wire             decoded_req,
  input wire             executed_req
);

  int unsigned fail_count = 0;

  // ******************************
  // Reset state
  // ******************************
  a_reset_state: assert property (@(posedge clk)
    rst |=> (!o_commit_req && !decoded_req && !executed_req && o_fetch_ready))
    else begin
      fail_count++;
      $error("Pipeline not idle after reset");
    end

  // Upstream may only pulse while decode can take it
  a_fetch_only_when_ready: assert property (@(posedge clk) disable iff (rst)
    i_fetched_req |-> o_fetch_ready)
    else begin
      fail_count++;
      $error("Fetched pulse while decode not ready");
    end

  // ******************************
  // Commit hold and back-pressure
  // ******************************
  a_commit_stable: assert property (@(posedge clk) disable iff (rst)
    (o_commit_req && !i_commit_ack) |=>
      (o_commit_req && $stable(o_commit_pc) && $stable(o_commit_rd) &&
       $stable(o_commit_wen) && $stable(o_commit_data) && $stable(o_commit_skip)))
    else begin
      fail_count++;
      $error("Commit report changed before its ack");
    end

  a_full_blocks_fetch: assert property (@(posedge clk) disable iff (rst)
    (decoded_req && executed_req && o_commit_req && !i_commit_ack) |-> !o_fetch_ready)
    else begin
      fail_count++;
      $error("Fetch ready with three instructions held");
    end

  // Empty pipeline gives a three edge latency
  a_empty_latency: assert property (@(posedge clk) disable iff (rst)
    (i_fetched_req && o_fetch_ready && !decoded_req && !executed_req && !o_commit_req)
      |-> ##3 o_commit_req)
    else begin
      fail_count++;
      $error("Commit did not appear three edges after fetch");
    end

endmodule

`default_nettype wire

// File: source/rv_core_top.sv
/* Core top, decode, execute and writeback stages */

`default_nettype none

`include "rv_settings.svh"

module rv_core_top
  import rv_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_fetched_req,
  input  wire [`BUS_64]    i_pc,
  input  wire [`BUS_32]    i_inst,
  input  wire              i_commit_ack,
  output logic             o_fetch_ready,
  output logic             o_commit_req,
  output logic [`BUS_64]   o_commit_pc,
  output logic [`BUS_RIDX] o_commit_rd,
  output logic             o_commit_wen,
  output logic [`BUS_64]   o_commit_data,
  output logic             o_commit_skip
);

  // Decode to execute
  logic             decoded_req;
  logic             decoded_ack;
  inst_op_t         dec_op;
  logic [`BUS_RIDX] dec_rd;
  logic             dec_rd_wen;
  logic [`BUS_64]   dec_op1;
  logic [`BUS_64]   dec_op2;
  logic [`BUS_64]   dec_pc;

  // Execute to writeback
  logic             executed_req;
  logic             executed_ack;
  logic             ex_busy;
  logic [`BUS_RIDX] ex_rd;
  logic             ex_rd_wen;
  logic [`BUS_64]   ex_result;
  logic [`BUS_64]   ex_pc;
  logic             ex_skip;

  // Register reads
  logic [`BUS_RIDX] rs1;
  logic [`BUS_RIDX] rs2;
  logic [`BUS_64]   rs1_data;
  logic [`BUS_64]   rs2_data;

  id_stage u_id (
    .clk (clk), .rst (rst),
    .i_fetched_req (i_fetched_req), .i_pc (i_pc), .i_inst (i_inst),
    .i_rs1_data (rs1_data), .i_rs2_data (rs2_data),
    .i_decoded_ack (decoded_ack),
    .i_ex_busy (ex_busy), .i_ex_rd (ex_rd), .i_ex_rd_wen (ex_rd_wen),
    .o_rs1 (rs1), .o_rs2 (rs2),
    .o_decoded_req (decoded_req), .o_fetch_ready (o_fetch_ready),
    .o_op (dec_op), .o_rd (dec_rd), .o_rd_wen (dec_rd_wen),
    .o_op1 (dec_op1), .o_op2 (dec_op2), .o_pc (dec_pc)
  );

  ex_stage u_ex (
    .clk (clk), .rst (rst),
    .i_decoded_req (decoded_req), .i_op (dec_op), .i_rd (dec_rd),
    .i_rd_wen (dec_rd_wen), .i_op1 (dec_op1), .i_op2 (dec_op2), .i_pc (dec_pc),
    .i_executed_ack (executed_ack),
    .o_decoded_ack (decoded_ack), .o_busy (ex_busy),
    .o_rd (ex_rd), .o_rd_wen (ex_rd_wen), .o_executed_req (executed_req),
    .o_result (ex_result), .o_pc (ex_pc), .o_skip (ex_skip)
  );

  wb_stage u_wb (
    .clk (clk), .rst (rst),
    .i_executed_req (executed_req), .i_rd (ex_rd), .i_rd_wen (ex_rd_wen),
    .i_result (ex_result), .i_pc (ex_pc), .i_skip (ex_skip),
    .i_rs1 (rs1), .i_rs2 (rs2), .i_commit_ack (i_commit_ack),
    .o_executed_ack (executed_ack),
    .o_rs1_data (rs1_data), .o_rs2_data (rs2_data),
    .o_commit_req (o_commit_req), .o_commit_pc (o_commit_pc),
    .o_commit_rd (o_commit_rd), .o_commit_wen (o_commit_wen),
    .o_commit_data (o_commit_data), .o_commit_skip (o_commit_skip)
  );

endmodule

`default_nettype wire

// File: source/wb_stage.sv
/* Writeback stage, integer register file and the commit report latch */

`default_nettype none

`include "rv_settings.svh"

module wb_stage
  import rv_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_executed_req,
  input  wire [`BUS_RIDX]  i_rd,
  input  wire              i_rd_wen,
  input  wire [`BUS_64]    i_result,
  input  wire [`BUS_64]    i_pc,
  input  wire              i_skip,
  input  wire [`BUS_RIDX]  i_rs1,
  input  wire [`BUS_RIDX]  i_rs2,
  input  wire              i_commit_ack,
  output logic             o_executed_ack,
  output logic [`BUS_64]   o_rs1_data,
  output logic [`BUS_64]   o_rs2_data,
  output logic             o_commit_req,
  output logic [`BUS_64]   o_commit_pc,
  output logic [`BUS_RIDX] o_commit_rd,
  output logic             o_commit_wen,
  output logic [`BUS_64]   o_commit_data,
  output logic             o_commit_skip
);

  wb_payload_t    in_payload;
  wb_payload_t    held;
  logic           accept_hs;
  logic [`BUS_64] regs [1:`REG_COUNT-1];   // x0 has no storage

  assign accept_hs = i_executed_req & o_executed_ack;

  // ******************************
  // Register file
  // ******************************
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (accept_hs && i_rd_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_result;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  always_comb begin
    in_payload.pc     = i_pc;
    in_payload.rd     = i_rd;
    in_payload.rd_wen = i_rd_wen;
    in_payload.data   = i_result;
    in_payload.skip   = i_skip;
  end

  stage_latch #(.payload_t(wb_payload_t)) u_latch (
    .clk           (clk),
    .rst           (rst),
    .i_fetched_req (accept_hs),
    .i_payload     (in_payload),
    .i_ack         (i_commit_ack),
    .o_req         (o_commit_req),
    .o_payload     (held),
    .o_accept      (o_executed_ack)
  );

  assign o_commit_pc   = held.pc;
  assign o_commit_rd   = held.rd;
  assign o_commit_wen  = held.rd_wen;
  assign o_commit_data = held.data;
  assign o_commit_skip = held.skip;

endmodule

`default_nettype wire

// File: source/ex_stage.sv
/* Execute stage, operation latch and the integer ALU */

`default_nettype none

`include "rv_settings.svh"

module ex_stage
  import rv_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_decoded_req,
  input  wire inst_op_t    i_op,
  input  wire [`BUS_RIDX]  i_rd,
  input  wire              i_rd_wen,
  input  wire [`BUS_64]    i_op1,
  input  wire [`BUS_64]    i_op2,
  input  wire [`BUS_64]    i_pc,
  input  wire              i_executed_ack,
  output logic             o_decoded_ack,
  output logic             o_busy,
  output logic [`BUS_RIDX] o_rd,
  output logic             o_rd_wen,
  output logic             o_executed_req,
  output logic [`BUS_64]   o_result,
  output logic [`BUS_64]   o_pc,
  output logic             o_skip
);

  ex_payload_t in_payload;
  ex_payload_t held;

  always_comb begin
    in_payload.op     = i_op;
    in_payload.rd     = i_rd;
    in_payload.rd_wen = i_rd_wen;
    in_payload.op1    = i_op1;
    in_payload.op2    = i_op2;
    in_payload.pc     = i_pc;
  end

  stage_latch #(.payload_t(ex_payload_t)) u_latch (
    .clk           (clk),
    .rst           (rst),
    .i_fetched_req (i_decoded_req & o_decoded_ack),   // Transfer edge from decode
    .i_payload     (in_payload),
    .i_ack         (i_executed_ack),
    .o_req         (o_executed_req),
    .o_payload     (held),
    .o_accept      (o_decoded_ack)
  );

  // ******************************
  // ALU
  // ******************************
  always_comb begin
    case (held.op)
      OP_ADD:  o_result = held.op1 + held.op2;
      OP_SUB:  o_result = held.op1 - held.op2;
      OP_AND:  o_result = held.op1 & held.op2;
      OP_OR:   o_result = held.op1 | held.op2;
      OP_XOR:  o_result = held.op1 ^ held.op2;
      OP_SLL:  o_result = held.op1 << held.op2[5:0];
      OP_SRL:  o_result = held.op1 >> held.op2[5:0];
      OP_LUI:  o_result = held.op2;
      default: o_result = held.op1;             // Skip passes the pc through
    endcase
  end

  assign o_busy   = o_executed_req;
  assign o_rd     = held.rd;
  assign o_rd_wen = held.rd_wen;
  assign o_pc     = held.pc;
  assign o_skip   = o_executed_req && (held.op == OP_SKIP);

endmodule

`default_nettype wire

// File: source/id_stage.sv
/* Decode stage, instruction latch, decoder and the
   read-after-write interlock against execute */

`default_nettype none

`include "rv_settings.svh"

module id_stage
  import rv_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_fetched_req,
  input  wire [`BUS_64]    i_pc,
  input  wire [`BUS_32]    i_inst,
  input  wire [`BUS_64]    i_rs1_data,
  input  wire [`BUS_64]    i_rs2_data,
  input  wire              i_decoded_ack,
  input  wire              i_ex_busy,
  input  wire [`BUS_RIDX]  i_ex_rd,
  input  wire              i_ex_rd_wen,
  output logic [`BUS_RIDX] o_rs1,
  output logic [`BUS_RIDX] o_rs2,
  output logic             o_decoded_req,
  output logic             o_fetch_ready,
  output inst_op_t         o_op,
  output logic [`BUS_RIDX] o_rd,
  output logic             o_rd_wen,
  output logic [`BUS_64]   o_op1,
  output logic [`BUS_64]   o_op2,
  output logic [`BUS_64]   o_pc
);

  id_payload_t in_payload;
  id_payload_t held;
  logic        held_req;
  logic        rs1_ren;
  logic        rs2_ren;
  logic        raw_hazard;

  assign in_payload.pc   = i_pc;
  assign in_payload.inst = i_inst;

  stage_latch #(.payload_t(id_payload_t)) u_latch (
    .clk           (clk),
    .rst           (rst),
    .i_fetched_req (i_fetched_req),
    .i_payload     (in_payload),
    .i_ack         (i_decoded_ack & ~raw_hazard),
    .o_req         (held_req),
    .o_payload     (held),
    .o_accept      (o_fetch_ready)
  );

  id_decoder u_decoder (
    .i_inst     (held.inst),
    .i_pc       (held.pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_op       (o_op),
    .o_rs1      (o_rs1),
    .o_rs2      (o_rs2),
    .o_rd       (o_rd),
    .o_rs1_ren  (rs1_ren),
    .o_rs2_ren  (rs2_ren),
    .o_rd_wen   (o_rd_wen),
    .o_op1      (o_op1),
    .o_op2      (o_op2)
  );

  // Older instruction in execute has not written its result yet
  assign raw_hazard = i_ex_busy && i_ex_rd_wen &&
                      ((rs1_ren && (o_rs1 == i_ex_rd)) || (rs2_ren && (o_rs2 == i_ex_rd)));

  assign o_decoded_req = held_req & ~raw_hazard;
  assign o_pc          = held.pc;

endmodule

`default_nettype wire

// File: source/id_decoder.sv
/* Combinational RV64I subset decoder, operation, register indices,
   enables and operand selection */

`default_nettype none

`include "rv_settings.svh"

module id_decoder
  import rv_pkg::*;
(
  input  wire [`BUS_32]    i_inst,
  input  wire [`BUS_64]    i_pc,
  input  wire [`BUS_64]    i_rs1_data,
  input  wire [`BUS_64]    i_rs2_data,
  output inst_op_t         o_op,
  output logic [`BUS_RIDX] o_rs1,
  output logic [`BUS_RIDX] o_rs2,
  output logic [`BUS_RIDX] o_rd,
  output logic             o_rs1_ren,
  output logic             o_rs2_ren,
  output logic             o_rd_wen,
  output logic [`BUS_64]   o_op1,
  output logic [`BUS_64]   o_op2
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic [6:0]     funct7;
  logic [`BUS_64] imm_i;
  logic [`BUS_64] imm_u;
  logic [`BUS_64] shamt;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rd   = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign shamt = {58'b0, i_inst[25:20]};   // RV64 shifts take 6 bits

  always_comb begin
    o_op      = OP_SKIP;
    o_rs1_ren = 1'b0;
    o_rs2_ren = 1'b0;
    o_op1     = i_pc;                      // Skipped word reports its pc
    o_op2     = '0;
    case (opcode)
      OPC_OP_IMM: begin
        case (funct3)
          3'b000: begin o_op = OP_ADD; o_op2 = imm_i; end
          3'b001: if (funct7[6:1] == 6'b0) begin o_op = OP_SLL; o_op2 = shamt; end
          3'b101: if (funct7[6:1] == 6'b0) begin o_op = OP_SRL; o_op2 = shamt; end
          default: ;
        endcase
        if (o_op != OP_SKIP) begin
          o_rs1_ren = 1'b1;
          o_op1     = i_rs1_data;
        end
      end
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: o_op = OP_ADD;
          10'b0100000_000: o_op = OP_SUB;
          10'b0000000_111: o_op = OP_AND;
          10'b0000000_110: o_op = OP_OR;
          10'b0000000_100: o_op = OP_XOR;
          default: ;
        endcase
        if (o_op != OP_SKIP) begin
          o_rs1_ren = 1'b1;
          o_rs2_ren = 1'b1;
          o_op1     = i_rs1_data;
          o_op2     = i_rs2_data;
        end
      end
      OPC_LUI: begin
        o_op  = OP_LUI;
        o_op1 = '0;
        o_op2 = imm_u;
      end
      default: ;
    endcase
  end

  // x0 destinations report no write
  assign o_rd_wen = (o_op != OP_SKIP) && (o_rd != '0);

endmodule

`default_nettype wire

// File: source/stage_latch.sv
/* Holding register for one pipeline item with the fetched pulse,
   req level and ack handshake */

`default_nettype none

module stage_latch #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     i_fetched_req,   // One-cycle capture pulse
  input  wire payload_t i_payload,
  input  wire logic     i_ack,
  output logic          o_req,
  output payload_t      o_payload,
  output logic          o_accept         // Free now, or draining on this edge
);

  payload_t held_payload;
  logic     drain;

  assign drain = o_req & i_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_req <= 1'b0;
    end else if (i_fetched_req) begin
      o_req <= 1'b1;                     // A refill on the drain edge keeps req high
    end else if (drain) begin
      o_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched_req) begin
      held_payload <= i_payload;
    end
  end

  assign o_payload = o_req ? held_payload : '0;
  assign o_accept  = ~o_req | drain;

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
/* Decoded operation enum and the stage payload structs
   for the decode, execute and writeback latches */

`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_LUI,
    OP_SKIP   // Unsupported word, commits with no write
  } inst_op_t;

  // Fetched instruction held in decode
  typedef struct packed {
    logic [`BUS_64]   pc;
    logic [`BUS_32]   inst;
  } id_payload_t;

  // Decoded operation held in execute
  typedef struct packed {
    inst_op_t         op;
    logic [`BUS_RIDX] rd;
    logic             rd_wen;
    logic [`BUS_64]   op1;
    logic [`BUS_64]   op2;
    logic [`BUS_64]   pc;
  } ex_payload_t;

  // Commit report held in writeback
  typedef struct packed {
    logic [`BUS_64]   pc;
    logic [`BUS_RIDX] rd;
    logic             rd_wen;
    logic [`BUS_64]   data;
    logic             skip;
  } wb_payload_t;

endpackage

`default_nettype wire

// File: source/rv_settings.svh
/* Bus width, register index width and register count macros */

`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data and pc width
`define BUS_64      63 : 0

// Instruction word width
`define BUS_32      31 : 0

// Register index width
`define BUS_RIDX    4 : 0

// Integer register count, x0 included
`define REG_COUNT   32

`endif
